// File: Bender.yml
package:
  name: modexp

export_include_dirs:
  - .

sources:
  - modexp_pkg.sv
  - mont_mul.sv
  - exp_sequencer.sv
  - modexp_top.sv
  - target: test
    files:
      - tb_clock_gen.sv
      - tb_modexp_checker.sv
      - tb_modexp.sv

// File: compile.f
+incdir+.
modexp_pkg.sv
mont_mul.sv
exp_sequencer.sv
modexp_top.sv
tb_clock_gen.sv
tb_modexp_checker.sv
tb_modexp.sv

// File: exp_sequencer.sv
// m must be odd; req is taken only on start while idle, and latency grows with the ones in y
`timescale 1ns/100ps
`include "modexp_defines.svh"

module exp_sequencer (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  start,
    input  modexp_pkg::me_req_t   req,
    input  logic                  mul_done,
    input  modexp_pkg::word_t     mul_p,
    output logic                  mul_start,
    output modexp_pkg::word_t     mul_a,
    output modexp_pkg::word_t     mul_b,
    output modexp_pkg::word_t     mul_m,
    output modexp_pkg::word_t     result,
    output logic                  done
);

    modexp_pkg::seq_state_t state;
    modexp_pkg::cnt_t       cnt;

    modexp_pkg::word_t      x_q;
    modexp_pkg::word_t      m_q;
    modexp_pkg::word_t      y_sh;
    modexp_pkg::word_t      r2;
    modexp_pkg::word_t      res;
    modexp_pkg::word_t      xm;

    modexp_pkg::acc_t       dbl;
    modexp_pkg::word_t      r2_next;
    logic                   accept;
    logic                   word_end;
    logic                   pre_last;
    logic                   y_msb;

    assign accept   = start && (state == modexp_pkg::st_idle);
    assign y_msb    = y_sh[`ME_WIDTH-1];

    // W-1 marks both the halfway point of the precompute and the last exponent bit
    assign word_end = (cnt == modexp_pkg::cnt_t'(`ME_WIDTH - 1));
    assign pre_last = (cnt == modexp_pkg::cnt_t'(2 * `ME_WIDTH - 1));

    // --------------------------------------------------
    // modular doubling for the R^2 precompute
    // --------------------------------------------------
    always_comb begin
        dbl = modexp_pkg::acc_t'(r2) << 1;
        // r2 < m, so one subtract is enough
        if (dbl >= modexp_pkg::acc_t'(m_q)) begin
            dbl = dbl - modexp_pkg::acc_t'(m_q);
        end
        r2_next = modexp_pkg::word_t'(dbl);
    end

    // --------------------------------------------------
    // operand select
    // --------------------------------------------------
    // b is kept below m in every phase
    always_comb begin
        case (state)
            modexp_pkg::st_to_mont: begin
                mul_a = x_q;
                mul_b = r2;
            end
            modexp_pkg::st_multiply: begin
                mul_a = xm;
                mul_b = res;
            end
            modexp_pkg::st_from_mont: begin
                mul_a = modexp_pkg::word_t'(1);
                mul_b = res;
            end
            default: begin
                mul_a = res;
                mul_b = res;
            end
        endcase
    end

    assign mul_m = m_q;

    // --------------------------------------------------
    // control FSM
    // --------------------------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state     <= modexp_pkg::st_idle;
            cnt       <= '0;
            mul_start <= 1'b0;
            done      <= 1'b0;
            result    <= '0;
        end else begin
            mul_start <= 1'b0;
            done      <= 1'b0;
            case (state)
                modexp_pkg::st_idle: begin
                    if (accept) begin
                        state <= modexp_pkg::st_precompute;
                        cnt   <= '0;
                    end
                end
                modexp_pkg::st_precompute: begin
                    cnt <= cnt + 1'b1;
                    if (pre_last) begin
                        state     <= modexp_pkg::st_to_mont;
                        mul_start <= 1'b1;
                    end
                end
                modexp_pkg::st_to_mont: begin
                    if (mul_done) begin
                        state     <= modexp_pkg::st_square;
                        cnt       <= '0;
                        mul_start <= 1'b1;
                    end
                end
                modexp_pkg::st_square: begin
                    if (mul_done) begin
                        mul_start <= 1'b1;
                        if (y_msb) begin
                            state <= modexp_pkg::st_multiply;
                        end else begin
                            cnt   <= cnt + 1'b1;
                            state <= word_end ? modexp_pkg::st_from_mont
                                              : modexp_pkg::st_square;
                        end
                    end
                end
                modexp_pkg::st_multiply: begin
                    if (mul_done) begin
                        mul_start <= 1'b1;
                        cnt       <= cnt + 1'b1;
                        state     <= word_end ? modexp_pkg::st_from_mont
                                              : modexp_pkg::st_square;
                    end
                end
                modexp_pkg::st_from_mont: begin
                    if (mul_done) begin
                        result <= mul_p;
                        done   <= 1'b1;
                        state  <= modexp_pkg::st_idle;
                    end
                end
                default: begin
                    state <= modexp_pkg::st_idle;
                end
            endcase
        end
    end

    // --------------------------------------------------
    // datapath registers
    // --------------------------------------------------
    always_ff @(posedge clk) begin
        case (state)
            modexp_pkg::st_idle: begin
                if (accept) begin
                    x_q  <= req.x;
                    m_q  <= req.m;
                    y_sh <= req.y;
                    // 1 mod m, which is 0 for m == 1
                    r2   <= (req.m == modexp_pkg::word_t'(1)) ? '0 : modexp_pkg::word_t'(1);
                end
            end
            modexp_pkg::st_precompute: begin
                r2 <= r2_next;
                // after W doublings r2 holds R mod m, the montgomery form of 1
                if (word_end) begin
                    res <= r2_next;
                end
            end
            modexp_pkg::st_to_mont: begin
                if (mul_done) begin
                    xm <= mul_p;
                end
            end
            modexp_pkg::st_square: begin
                if (mul_done) begin
                    res <= mul_p;
                    if (!y_msb) begin
                        y_sh <= y_sh << 1;
                    end
                end
            end
            modexp_pkg::st_multiply: begin
                if (mul_done) begin
                    res  <= mul_p;
                    y_sh <= y_sh << 1;
                end
            end
        endcase
    end

endmodule

// File: modexp_defines.svh
// width macros for the whole engine; ME_WIDTH must be 8 or more and is fixed at compile time

`ifndef MODEXP_DEFINES_SVH
`define MODEXP_DEFINES_SVH

// operand word width
`define ME_WIDTH 32

// counters run up to 2*ME_WIDTH during the R-squared precompute
`define ME_CNT_WIDTH ($clog2(2 * `ME_WIDTH) + 1)

`endif

// File: modexp_pkg.sv
// shared types of the engine; all widths follow the macros in modexp_defines.svh

`include "modexp_defines.svh"

package modexp_pkg;

    // operand, modulus and result
    typedef logic [`ME_WIDTH-1:0] word_t;

    // multiplier accumulator, stays below 4*m
    typedef logic [`ME_WIDTH+1:0] acc_t;

    typedef logic [`ME_CNT_WIDTH-1:0] cnt_t;

    typedef struct packed {
        word_t x;
        word_t y;
        word_t m;
    } me_req_t;

    typedef enum logic [2:0] {
        st_idle,
        st_precompute,
        st_to_mont,
        st_square,
        st_multiply,
        st_from_mont
    } seq_state_t;

endpackage

// File: modexp_top.sv
// computes x^y mod m for one-word operands; m must be odd and a start while busy is dropped
`timescale 1ns/100ps

module modexp_top (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  start,
    input  modexp_pkg::me_req_t   req,
    output modexp_pkg::word_t     result,
    output logic                  done
);

    logic              mul_start;
    logic              mul_done;
    modexp_pkg::word_t mul_a;
    modexp_pkg::word_t mul_b;
    modexp_pkg::word_t mul_m;
    modexp_pkg::word_t mul_p;

    // --------------------------------------------------
    // control sequencer
    // --------------------------------------------------
    exp_sequencer u_seq (
        .clk       (clk),
        .rst_n     (rst_n),
        .start     (start),
        .req       (req),
        .mul_done  (mul_done),
        .mul_p     (mul_p),
        .mul_start (mul_start),
        .mul_a     (mul_a),
        .mul_b     (mul_b),
        .mul_m     (mul_m),
        .result    (result),
        .done      (done)
    );

    // --------------------------------------------------
    // montgomery multiplier
    // --------------------------------------------------
    mont_mul u_mul (
        .clk       (clk),
        .rst_n     (rst_n),
        .mul_start (mul_start),
        .a         (mul_a),
        .b         (mul_b),
        .m         (mul_m),
        .done      (mul_done),
        .p         (mul_p)
    );

endmodule

// File: mont_mul.sv
// m must be odd and b below m; start only while idle, done follows ME_WIDTH+1 cycles later
`timescale 1ns/100ps
`include "modexp_defines.svh"

module mont_mul (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                mul_start,
    input  modexp_pkg::word_t   a,
    input  modexp_pkg::word_t   b,
    input  modexp_pkg::word_t   m,
    output logic                done,
    output modexp_pkg::word_t   p
);

    modexp_pkg::word_t a_sh;
    modexp_pkg::word_t b_q;
    modexp_pkg::word_t m_q;
    modexp_pkg::acc_t  acc;
    modexp_pkg::cnt_t  cnt;
    logic              busy;
    logic              fin;

    modexp_pkg::word_t a_cur;
    modexp_pkg::word_t b_cur;
    modexp_pkg::word_t m_cur;
    modexp_pkg::acc_t  acc_cur;
    modexp_pkg::acc_t  acc_add;
    modexp_pkg::acc_t  acc_next;
    logic              acc_ge_m;

    // --------------------------------------------------
    // one radix-2 step
    // --------------------------------------------------
    // first step runs in the start cycle straight off the inputs
    always_comb begin
        if (mul_start) begin
            a_cur   = a;
            b_cur   = b;
            m_cur   = m;
            acc_cur = '0;
        end else begin
            a_cur   = a_sh;
            b_cur   = b_q;
            m_cur   = m_q;
            acc_cur = acc;
        end
        acc_add = acc_cur;
        if (a_cur[0]) begin
            acc_add = acc_add + modexp_pkg::acc_t'(b_cur);
        end
        // make it even so the halving is exact
        if (acc_add[0]) begin
            acc_add = acc_add + modexp_pkg::acc_t'(m_cur);
        end
        acc_next = acc_add >> 1;
    end

    assign acc_ge_m = (acc >= modexp_pkg::acc_t'(m_q));

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy <= 1'b0;
            fin  <= 1'b0;
            cnt  <= '0;
            done <= 1'b0;
        end else begin
            done <= fin;
            fin  <= 1'b0;
            if (mul_start) begin
                busy <= 1'b1;
                cnt  <= modexp_pkg::cnt_t'(1);
            end else if (busy) begin
                cnt <= cnt + 1'b1;
                if (cnt == modexp_pkg::cnt_t'(`ME_WIDTH - 1)) begin
                    busy <= 1'b0;
                    fin  <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (mul_start || busy) begin
            acc  <= acc_next;
            a_sh <= a_cur >> 1;
        end
        if (mul_start) begin
            b_q <= b;
            m_q <= m;
        end
        // acc < 2m here, so a single subtract lands below m
        if (fin) begin
            p <= acc_ge_m ? modexp_pkg::word_t'(acc - modexp_pkg::acc_t'(m_q))
                          : modexp_pkg::word_t'(acc);
        end
    end

endmodule

// File: tb_clock_gen.sv
// free-running testbench clock; rst_n is released on a falling edge after RESET_CYCLES rising edges
`timescale 1ns/100ps

module tb_clock_gen #(
    parameter int PERIOD_NS    = 8,
    parameter int RESET_CYCLES = 2
) (
    output logic clk,
    output logic rst_n
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD_NS / 2) clk = ~clk;
    end

    initial begin
        rst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
    end

endmodule

// File: tb_modexp.sv
// random and directed requests against modexp_top; moduli are always odd, one request at a time
`timescale 1ns/100ps
`include "modexp_defines.svh"

module tb_modexp;

    localparam int W            = `ME_WIDTH;
    localparam int DONE_TIMEOUT = 2 * W + (2 * W + 2) * (W + 2) + 64;
    localparam int NUM_RANDOM   = 40;

    logic                clk;
    logic                rst_n;
    logic                start;
    modexp_pkg::me_req_t req;
    modexp_pkg::word_t   result;
    logic                done;
    int                  chk_errors;
    int                  chk_count;
    logic                chk_pending;
    int                  seed;
    int                  tb_errors;
    int                  timeouts;

    tb_clock_gen u_clk (
        .clk   (clk),
        .rst_n (rst_n)
    );

    modexp_top i_dut (
        .clk    (clk),
        .rst_n  (rst_n),
        .start  (start),
        .req    (req),
        .result (result),
        .done   (done)
    );

    tb_modexp_checker u_chk (
        .clk         (clk),
        .rst_n       (rst_n),
        .start       (start),
        .req         (req),
        .result      (result),
        .done        (done),
        .error_count (chk_errors),
        .check_count (chk_count),
        .pending     (chk_pending)
    );

    function automatic modexp_pkg::word_t rand_word();
        modexp_pkg::word_t w;
        logic [31:0]       r;
        int                i;
        w = '0;
        for (i = 0; i < W; i += 32) begin
            r = $random(seed);
            w = (w << 32) | modexp_pkg::word_t'(r);
        end
        return w;
    endfunction

    task automatic wait_done();
        int n;
        n = 0;
        while (!done && n < DONE_TIMEOUT) begin
            @(negedge clk);
            n++;
        end
        if (!done) begin
            timeouts++;
            $display("timeout at %0t: no done within %0d cycles", $time, DONE_TIMEOUT);
        end
    endtask

    task automatic run_request(input modexp_pkg::word_t x_in, y_in, m_in);
        if (timeouts == 0) begin
            @(negedge clk);
            start = 1'b1;
            req.x = x_in;
            req.y = y_in;
            req.m = m_in;
            @(negedge clk);
            start = 1'b0;
            // scramble req so only the captured copy counts
            req.x = rand_word();
            req.y = rand_word();
            req.m = rand_word();
            wait_done();
        end
    endtask

    // --------------------------------------------------
    // starts while busy must be dropped
    // --------------------------------------------------
    task automatic busy_start_test();
        int n;
        int extra;
        if (timeouts == 0) begin
            @(negedge clk);
            start = 1'b1;
            req.x = rand_word();
            req.y = rand_word();
            req.m = rand_word() | 1'b1;
            n     = 0;
            extra = 0;
            while (!done && n < DONE_TIMEOUT) begin
                @(negedge clk);
                n++;
                // one lands in the precompute and one in the exponent loop
                start = (n == 3) || (n == 3 * W + 5);
                req.x = rand_word();
                req.y = rand_word();
                req.m = rand_word() | 1'b1;
            end
            start = 1'b0;
            if (!done) begin
                timeouts++;
                $display("timeout at %0t: no done after a start while busy", $time);
            end else begin
                for (n = 0; n < DONE_TIMEOUT; n++) begin
                    @(negedge clk);
                    if (done) begin
                        extra++;
                    end
                end
                if (extra != 0) begin
                    tb_errors++;
                    $display("%0d extra done strobes after starts while busy", extra);
                end
            end
        end
    endtask

    initial begin
        modexp_pkg::word_t m;
        int                i;
        int                n;
        seed      = 87798;
        start     = 1'b0;
        req       = '0;
        tb_errors = 0;
        timeouts  = 0;
        n         = 0;
        while (rst_n !== 1'b1 && n < 100) begin
            @(negedge clk);
            n++;
        end
        if (rst_n !== 1'b1) begin
            timeouts++;
            $display("reset was never released");
        end
        // idle after reset
        for (i = 0; i < 20; i++) begin
            @(negedge clk);
            if (done) begin
                tb_errors++;
                $display("done raised at %0t before any start", $time);
            end
        end

        for (i = 0; i < NUM_RANDOM; i++) begin
            run_request(rand_word(), rand_word(), rand_word() | 1'b1);
        end

        // zero exponent and unit modulus
        m = rand_word() | 1'b1;
        run_request(rand_word(), '0, m);
        run_request(rand_word(), '0, 1);
        run_request(rand_word(), rand_word(), 1);

        // base above, equal to and below a small modulus
        m = (rand_word() & 'hffff) | 1'b1;
        run_request(rand_word(), rand_word(), m);
        run_request(m, rand_word(), m);
        run_request('0, rand_word(), m);
        run_request(rand_word(), rand_word(), '1);

        // longest and shortest paths through the loop
        run_request(rand_word(), '1, rand_word() | 1'b1);
        run_request(rand_word(), modexp_pkg::word_t'(1) << (W - 1), rand_word() | 1'b1);

        busy_start_test();

        repeat (4) @(negedge clk);
        if (chk_pending) begin
            tb_errors++;
            $display("an accepted request never completed");
        end
        $display("errors: %0d checker, %0d testbench, %0d timeouts; %0d results checked",
                 chk_errors, tb_errors, timeouts, chk_count);
        if (chk_errors + tb_errors + timeouts == 0 && chk_count > 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

// File: tb_modexp_checker.sv
// compares each done against a software model; assumes one request in flight, as the DUT does
`timescale 1ns/100ps
`include "modexp_defines.svh"

module tb_modexp_checker (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                start,
    input  modexp_pkg::me_req_t req,
    input  modexp_pkg::word_t   result,
    input  logic                done,
    output int                  error_count,
    output int                  check_count,
    output logic                pending
);

    localparam int W         = `ME_WIDTH;
    localparam int LAT_LIMIT = 2 * W + (2 * W + 2) * (W + 2) + 32;

    modexp_pkg::me_req_t req_q[$];
    modexp_pkg::me_req_t cur;
    modexp_pkg::word_t   expected;
    int                  busy_cycles;

    // plain square-and-multiply, msb first, in double width
    function automatic modexp_pkg::word_t modexp_model(input modexp_pkg::me_req_t r);
        logic [2*W-1:0] m_w;
        logic [2*W-1:0] base;
        logic [2*W-1:0] acc;
        int             i;
        m_w  = {{W{1'b0}}, r.m};
        base = {{W{1'b0}}, r.x} % m_w;
        acc  = {{(2*W-1){1'b0}}, 1'b1} % m_w;
        for (i = W - 1; i >= 0; i--) begin
            acc = (acc * acc) % m_w;
            if (r.y[i]) begin
                acc = (acc * base) % m_w;
            end
        end
        return modexp_pkg::word_t'(acc);
    endfunction

    initial begin
        error_count = 0;
        check_count = 0;
        pending     = 1'b0;
        busy_cycles = 0;
    end

    // --------------------------------------------------
    // request capture at the rising edge
    // --------------------------------------------------
    always @(posedge clk) begin
        if (rst_n) begin
            if (start && !pending) begin
                req_q.push_back(req);
                pending     = 1'b1;
                busy_cycles = 0;
            end else if (pending) begin
                busy_cycles++;
                if (busy_cycles == LAT_LIMIT) begin
                    error_count++;
                    $display("no done within %0d cycles of an accepted start (m=%h)",
                             LAT_LIMIT, req_q[0].m);
                end
            end
        end
    end

    // --------------------------------------------------
    // result compare at the falling edge
    // --------------------------------------------------
    always @(negedge clk) begin
        if (rst_n && done) begin
            if (req_q.size() == 0) begin
                error_count++;
                $display("done strobe at %0t with no accepted request outstanding", $time);
            end else begin
                cur      = req_q.pop_front();
                expected = modexp_model(cur);
                check_count++;
                if (result !== expected) begin
                    error_count++;
                    $display("FAIL %0t: x=%h y=%h m=%h result %h expected %h",
                             $time, cur.x, cur.y, cur.m, result, expected);
                end
                pending     = 1'b0;
                busy_cycles = 0;
            end
        end
    end

endmodule
